/* Bender.yml */
package:
  name: rv_exec_core

sources:
  - include_dirs:
      - .
    files:
      - rv_pkg.sv
      - exec_if.sv
      - decoder.sv
      - regfile.sv
      - alu.sv
      - branch_cmp.sv
      - fetch_ctrl.sv
      - rv_exec_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_rv_exec_core.sv

/* alu.sv */
`timescale 1ns/1ps

module alu
    import rv_pkg::*;
(
    exec_if.alu_side ex,
    output word_t    result,
    output addr_t    new_pc
);
    // W forms work on the low word and sign-extend bit 31 of the result.
    function automatic word_t sext_w(input u32 value);
        return {{32{value[31]}}, value};
    endfunction

    always_comb begin
        result = '0;
        new_pc = '0;
        unique case (ex.op)
            ADD:  result = ex.op1 + ex.op2;
            SUB:  result = ex.op1 - ex.op2;
            AND:  result = ex.op1 & ex.op2;
            OR:   result = ex.op1 | ex.op2;
            XOR:  result = ex.op1 ^ ex.op2;
            ADDI: result = ex.op1 + ex.immed;
            XORI: result = ex.op1 ^ ex.immed;
            ORI:  result = ex.op1 | ex.immed;
            ANDI: result = ex.op1 & ex.immed;

            ADDW:  result = sext_w(ex.op1[31:0] + ex.op2[31:0]);
            SUBW:  result = sext_w(ex.op1[31:0] - ex.op2[31:0]);
            ADDIW: result = sext_w(ex.op1[31:0] + ex.immed[31:0]);

            // Only the effective address, no data access happens.
            LD, LB, LH, LW, LBU, LHU, LWU, SD, SB, SH, SW: result = ex.op1 + ex.immed;

            LUI:   result = ex.immed;
            AUIPC: result = ex.pc + ex.immed;

            JAL: begin
                result = ex.pc + 64'd4;
                new_pc = ex.pc + ex.immed;
            end
            JALR: begin
                result = ex.pc + 64'd4;
                new_pc = ex.op1 + ex.immed; // bit 0 is cleared by the fetch side
            end

            BEQ, BNE, BLT, BGE, BLTU, BGEU: new_pc = ex.pc + ex.immed;

            SLL:  result = ex.op1 << ex.op2[5:0];
            SRL:  result = ex.op1 >> ex.op2[5:0];
            SRA:  result = $signed(ex.op1) >>> ex.op2[5:0];
            SLLI: result = ex.op1 << ex.immed[5:0];
            SRLI: result = ex.op1 >> ex.immed[5:0];
            SRAI: result = $signed(ex.op1) >>> ex.immed[5:0];

            SLT:   result = {63'd0, $signed(ex.op1) < $signed(ex.op2)};
            SLTI:  result = {63'd0, $signed(ex.op1) < $signed(ex.immed)};
            SLTU:  result = {63'd0, ex.op1 < ex.op2};
            SLTIU: result = {63'd0, ex.op1 < ex.immed};

            SLLW:  result = sext_w(ex.op1[31:0] << ex.op2[4:0]);
            SRLW:  result = sext_w(ex.op1[31:0] >> ex.op2[4:0]);
            SRAW:  result = sext_w($signed(ex.op1[31:0]) >>> ex.op2[4:0]);
            SLLIW: result = sext_w(ex.op1[31:0] << ex.immed[4:0]);
            SRLIW: result = sext_w(ex.op1[31:0] >> ex.immed[4:0]);
            SRAIW: result = sext_w($signed(ex.op1[31:0]) >>> ex.immed[4:0]);

            default: ; // ILLEGAL leaves both outputs at zero.
        endcase
    end
endmodule

/* branch_cmp.sv */
`timescale 1ns/1ps

module branch_cmp
    import rv_pkg::*;
(
    exec_if.alu_side ex,
    output logic     taken
);
    always_comb begin
        unique case (ex.op)
            BEQ:  taken = (ex.op1 == ex.op2);
            BNE:  taken = (ex.op1 != ex.op2);
            BLT:  taken = ($signed(ex.op1) < $signed(ex.op2));
            BGE:  taken = ($signed(ex.op1) >= $signed(ex.op2));
            BLTU: taken = (ex.op1 < ex.op2);
            BGEU: taken = (ex.op1 >= ex.op2);

            // Jumps always redirect.
            JAL, JALR: taken = 1'b1;

            default: taken = 1'b0;
        endcase
    end
endmodule

/* decoder.sv */
`timescale 1ns/1ps

module decoder
    import rv_pkg::*;
(
    input  u32       instr,
    exec_if.src      dec,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output logic     rd_we
);
    localparam logic [6:0] OPC_LUI     = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
    localparam logic [6:0] OPC_JAL     = 7'b1101111;
    localparam logic [6:0] OPC_JALR    = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;
    localparam logic [6:0] OPC_STORE   = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMMW = 7'b0011011;
    localparam logic [6:0] OPC_OP      = 7'b0110011;
    localparam logic [6:0] OPC_OPW     = 7'b0111011;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    word_t           imm_i;
    word_t           imm_s;
    word_t           imm_b;
    word_t           imm_u;
    word_t           imm_j;
    instruction_type op;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        unique case (opcode)
            OPC_LUI, OPC_AUIPC: dec.immed = imm_u;
            OPC_JAL:            dec.immed = imm_j;
            OPC_BRANCH:         dec.immed = imm_b;
            OPC_STORE:          dec.immed = imm_s;
            default:            dec.immed = imm_i; // I-type, also harmless for R-type.
        endcase
    end

    always_comb begin
        op = ILLEGAL; // Anything not matched below stays illegal.
        case (opcode)
            OPC_LUI:   op = LUI;
            OPC_AUIPC: op = AUIPC;
            OPC_JAL:   op = JAL;
            OPC_JALR:  if (funct3 == 3'b000) op = JALR;
            OPC_BRANCH: case (funct3)
                3'b000: op = BEQ;
                3'b001: op = BNE;
                3'b100: op = BLT;
                3'b101: op = BGE;
                3'b110: op = BLTU;
                3'b111: op = BGEU;
            endcase
            OPC_LOAD: case (funct3)
                3'b000: op = LB;
                3'b001: op = LH;
                3'b010: op = LW;
                3'b011: op = LD;
                3'b100: op = LBU;
                3'b101: op = LHU;
                3'b110: op = LWU;
            endcase
            OPC_STORE: case (funct3)
                3'b000: op = SB;
                3'b001: op = SH;
                3'b010: op = SW;
                3'b011: op = SD;
            endcase
            OPC_OP_IMM: case (funct3)
                3'b000: op = ADDI;
                3'b010: op = SLTI;
                3'b011: op = SLTIU;
                3'b100: op = XORI;
                3'b110: op = ORI;
                3'b111: op = ANDI;
                3'b001: if (instr[31:26] == 6'b000000) op = SLLI;
                3'b101: if (instr[31:26] == 6'b000000) op = SRLI;
                        else if (instr[31:26] == 6'b010000) op = SRAI;
            endcase
            OPC_OP_IMMW: case ({funct7, funct3})
                10'b0000000_001: op = SLLIW;
                10'b0000000_101: op = SRLIW;
                10'b0100000_101: op = SRAIW;
                default: if (funct3 == 3'b000) op = ADDIW;
            endcase
            OPC_OP: case ({funct7, funct3})
                10'b0000000_000: op = ADD;
                10'b0100000_000: op = SUB;
                10'b0000000_001: op = SLL;
                10'b0000000_010: op = SLT;
                10'b0000000_011: op = SLTU;
                10'b0000000_100: op = XOR;
                10'b0000000_101: op = SRL;
                10'b0100000_101: op = SRA;
                10'b0000000_110: op = OR;
                10'b0000000_111: op = AND;
            endcase
            OPC_OPW: case ({funct7, funct3})
                10'b0000000_000: op = ADDW;
                10'b0100000_000: op = SUBW;
                10'b0000000_001: op = SLLW;
                10'b0000000_101: op = SRLW;
                10'b0100000_101: op = SRAW;
            endcase
        endcase
    end

    assign dec.op = op;

    always_comb begin
        unique case (op)
            BEQ, BNE, BLT, BGE, BLTU, BGEU: rd_we = 1'b0;
            SB, SH, SW, SD, ILLEGAL:        rd_we = 1'b0;
            default:                        rd_we = (rd != '0); // x0 is never written
        endcase
    end

    // An unknown encoding must never reach the register file.
    always_comb begin
        a_no_illegal_write: assert #0 (!(rd_we && op == ILLEGAL))
            else $error("write enable raised for an illegal encoding");
    end
endmodule

/* exec_if.sv */
`timescale 1ns/1ps

interface exec_if
    import rv_pkg::*;
();
    instruction_type op;
    word_t           op1;
    word_t           op2;
    word_t           immed;
    addr_t           pc; // PC of the instruction being executed.

    modport src (
        output op,
        output immed
    );

    modport alu_side (
        input op,
        input op1,
        input op2,
        input immed,
        input pc
    );
endinterface

/* fetch_ctrl.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module fetch_ctrl
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    output logic            wb_cyc,
    output logic            wb_stb,
    output addr_t           wb_adr,
    input  u32              wb_dat,
    input  logic            wb_ack,
    output u32              instr,
    output addr_t           pc,
    output logic            exec,
    input  logic            taken,
    input  addr_t           new_pc,
    input  instruction_type op
);
    fetch_state_t state;
    fetch_state_t state_nxt;
    addr_t        pc_nxt;

    always_comb begin
        state_nxt = state;
        unique case (state)
            FS_IDLE:  state_nxt = FS_FETCH;
            FS_FETCH: if (wb_ack) state_nxt = FS_EXEC; // Hold the request until acked.
            FS_EXEC:  state_nxt = FS_FETCH;
            default:  state_nxt = FS_IDLE;
        endcase
    end

    always_comb begin
        pc_nxt = pc + 64'd4;
        if (taken) begin
            pc_nxt = new_pc;
            if (op == JALR) pc_nxt[0] = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= FS_IDLE;
            pc    <= `RV_RESET_PC;
            instr <= '0;
        end else begin
            state <= state_nxt;
            if (state == FS_FETCH && wb_ack) instr <= wb_dat;
            if (state == FS_EXEC) pc <= pc_nxt; // Same edge as the register write.
        end
    end

    assign wb_cyc = (state == FS_FETCH);
    assign wb_stb = (state == FS_FETCH);
    assign wb_adr = pc;
    assign exec   = (state == FS_EXEC);

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!arst_n)
        wb_stb |-> wb_cyc);

    // The slave may stall for any number of cycles without seeing the request change.
    a_adr_stable: assert property (@(posedge clk) disable iff (!arst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr));

    a_exec_single: assert property (@(posedge clk) disable iff (!arst_n)
        exec |=> !exec);
endmodule

/* project.f */
+incdir+.
rv_pkg.sv
exec_if.sv
decoder.sv
regfile.sv
alu.sv
branch_cmp.sv
fetch_ctrl.sv
rv_exec_core.sv
tb_rv_exec_core.sv

/* regfile.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module regfile
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rdata1,
    output word_t    rdata2,
    input  reg_idx_t rd,
    input  logic     we,
    input  word_t    wdata
);
    word_t regs [`RV_NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // Reads are combinational. A write shows up after the next edge.
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];
endmodule

/* rv_exec_core.sv */
`timescale 1ns/1ps

module rv_exec_core
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    output logic     wb_cyc,
    output logic     wb_stb,
    output addr_t    wb_adr,
    input  u32       wb_dat,
    input  logic     wb_ack,
    output logic     retire_valid,
    output addr_t    retire_pc,
    output reg_idx_t retire_rd,
    output logic     retire_we,
    output word_t    retire_value,
    output logic     retire_illegal
);
    exec_if ex_bus ();

    u32       instr;
    addr_t    pc;
    logic     exec;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic     rd_we;
    word_t    rdata1;
    word_t    rdata2;
    word_t    result;
    addr_t    new_pc;
    logic     taken;

    fetch_ctrl fetch_ctrl_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_adr (wb_adr),
        .wb_dat (wb_dat),
        .wb_ack (wb_ack),
        .instr  (instr),
        .pc     (pc),
        .exec   (exec),
        .taken  (taken),
        .new_pc (new_pc),
        .op     (ex_bus.op)
    );

    decoder decoder_inst (
        .instr (instr),
        .dec   (ex_bus.src),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd),
        .rd_we (rd_we)
    );

    regfile regfile_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .rs1    (rs1),
        .rs2    (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .rd     (rd),
        .we     (rd_we && exec), // Commit only in the execute cycle.
        .wdata  (result)
    );

    assign ex_bus.op1 = rdata1;
    assign ex_bus.op2 = rdata2;
    assign ex_bus.pc  = pc;

    alu alu_inst (
        .ex     (ex_bus.alu_side),
        .result (result),
        .new_pc (new_pc)
    );

    branch_cmp branch_cmp_inst (
        .ex    (ex_bus.alu_side),
        .taken (taken)
    );

    assign retire_valid   = exec;
    assign retire_pc      = pc;
    assign retire_rd      = rd;
    assign retire_we      = rd_we;
    assign retire_value   = result;
    assign retire_illegal = (ex_bus.op == ILLEGAL);
endmodule

/* rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Address of the first instruction fetched after reset.
`define RV_RESET_PC 64'h0

// Architectural integer registers, x0 included.
`define RV_NUM_REGS 32

`endif

/* rv_pkg.sv */
`include "rv_params.svh"

package rv_pkg;

    typedef logic [63:0] word_t;
    typedef logic [63:0] addr_t;
    typedef logic [31:0] u32;
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t;

    // Every operation the ALU knows, plus a marker for unknown encodings.
    typedef enum logic [5:0] {
        ADD, SUB, AND, OR, XOR,
        ADDI, XORI, ORI, ANDI,
        ADDW, SUBW, ADDIW,
        LD, LB, LH, LW, LBU, LHU, LWU,
        SD, SB, SH, SW,
        LUI, AUIPC,
        JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        SLL, SRL, SRA,
        SLLI, SRLI, SRAI,
        SLT, SLTI, SLTU, SLTIU,
        SLLW, SRLW, SRAW,
        SLLIW, SRLIW, SRAIW,
        ILLEGAL
    } instruction_type;

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_FETCH,
        FS_EXEC
    } fetch_state_t;

endpackage

/* tb_rv_exec_core.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_rv_exec_core
    import rv_pkg::*;
();
    localparam logic [6:0] OP_IMM   = 7'h13;
    localparam logic [6:0] OP_IMMW  = 7'h1B;
    localparam logic [6:0] OP_REG   = 7'h33;
    localparam logic [6:0] OP_REGW  = 7'h3B;
    localparam logic [6:0] OP_LUI   = 7'h37;
    localparam logic [6:0] OP_AUIPC = 7'h17;
    localparam logic [6:0] OP_JALR  = 7'h67;
    localparam logic [6:0] OP_LOAD  = 7'h03;

    logic     clk;
    logic     arst_n;
    logic     wb_cyc;
    logic     wb_stb;
    addr_t    wb_adr;
    u32       wb_dat;
    logic     wb_ack;
    logic     retire_valid;
    addr_t    retire_pc;
    reg_idx_t retire_rd;
    logic     retire_we;
    word_t    retire_value;
    logic     retire_illegal;

    // Expected-value table, one entry per retired instruction in program order.
    string    row_name[$];
    addr_t    row_pc[$];
    reg_idx_t row_rd[$];
    logic     row_we[$];
    word_t    row_value[$];
    logic     row_ill[$];
    addr_t    row_next[$];
    int       num_rows;
    logic     build_done = 1'b0;
    addr_t    build_pc;

    u32          mem [128];
    logic [31:0] lfsr = 32'h1f17_9c8c;
    int          errors = 0;
    int          fetch_count = 0;

    rv_exec_core rv_exec_core_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_adr         (wb_adr),
        .wb_dat         (wb_dat),
        .wb_ack         (wb_ack),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_rd      (retire_rd),
        .retire_we      (retire_we),
        .retire_value   (retire_value),
        .retire_illegal (retire_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps 32, 22, 2 and 1 give a maximal-length sequence.
    function automatic logic next_rand_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic u32 enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                 input logic [4:0] rs1, input logic [2:0] f3,
                                 input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic u32 enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                 input logic [2:0] f3, input logic [4:0] rd,
                                 input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic u32 enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                 input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic u32 enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                 input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic u32 enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                 input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic u32 enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
    endfunction

    task automatic check_eq(input string name, input string field,
                            input logic [63:0] expected, input logic [63:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", name, field, expected, actual);
            errors++;
        end
    endtask

    // The row's PC follows from the previous row's next PC.
    task automatic add_row(input string name, input u32 instr, input reg_idx_t rd,
                           input logic we, input word_t value, input logic ill,
                           input addr_t next_pc);
        row_name.push_back(name);
        row_pc.push_back(build_pc);
        row_rd.push_back(rd);
        row_we.push_back(we);
        row_value.push_back(value);
        row_ill.push_back(ill);
        row_next.push_back(next_pc);
        mem[build_pc[8:2]] = instr;
        build_pc = next_pc;
        num_rows++;
    endtask

    task automatic build_program();
        for (int i = 0; i < 128; i++) begin
            mem[i] = 32'hA5A5_0000 ^ (i * 4); // Never fetched unless control flow is wrong.
        end
        build_pc = `RV_RESET_PC;
        num_rows = 0;
        add_row("addi_neg", enc_i(-5, 0, 0, 1, OP_IMM), 1, 1, 64'hFFFF_FFFF_FFFF_FFFB, 0, 'h04);
        add_row("addi_pos", enc_i(12, 0, 0, 2, OP_IMM), 2, 1, 64'hC, 0, 'h08);
        add_row("xori", enc_i('h0F0, 1, 4, 3, OP_IMM), 3, 1, 64'hFFFF_FFFF_FFFF_FF0B, 0, 'h0C);
        add_row("ori", enc_i('h701, 2, 6, 4, OP_IMM), 4, 1, 64'h70D, 0, 'h10);
        add_row("andi", enc_i('h7FF, 1, 7, 5, OP_IMM), 5, 1, 64'h7FB, 0, 'h14);
        add_row("lui_neg", enc_u('h80000, 6, OP_LUI), 6, 1, 64'hFFFF_FFFF_8000_0000, 0, 'h18);
        add_row("addi_x0", enc_i(1, 1, 0, 0, OP_IMM), 0, 0, 64'hFFFF_FFFF_FFFF_FFFC, 0, 'h1C);
        add_row("add", enc_r(0, 2, 1, 0, 7, OP_REG), 7, 1, 64'h7, 0, 'h20);
        add_row("sub", enc_r('h20, 2, 1, 0, 8, OP_REG), 8, 1, 64'hFFFF_FFFF_FFFF_FFEF, 0, 'h24);
        add_row("and", enc_r(0, 4, 1, 7, 9, OP_REG), 9, 1, 64'h709, 0, 'h28);
        add_row("or", enc_r(0, 5, 2, 6, 10, OP_REG), 10, 1, 64'h7FF, 0, 'h2C);
        add_row("xor", enc_r(0, 2, 1, 4, 11, OP_REG), 11, 1, 64'hFFFF_FFFF_FFFF_FFF7, 0, 'h30);
        add_row("slt", enc_r(0, 2, 1, 2, 12, OP_REG), 12, 1, 64'h1, 0, 'h34);
        add_row("sltu", enc_r(0, 2, 1, 3, 13, OP_REG), 13, 1, 64'h0, 0, 'h38);
        add_row("slti", enc_i(-4, 1, 2, 14, OP_IMM), 14, 1, 64'h1, 0, 'h3C);
        add_row("sltiu", enc_i(-1, 2, 3, 15, OP_IMM), 15, 1, 64'h1, 0, 'h40);
        add_row("sll", enc_r(0, 1, 2, 1, 16, OP_REG), 16, 1, 64'h6000_0000_0000_0000, 0, 'h44);
        add_row("srl", enc_r(0, 2, 1, 5, 17, OP_REG), 17, 1, 64'h000F_FFFF_FFFF_FFFF, 0, 'h48);
        add_row("sra", enc_r('h20, 2, 6, 5, 18, OP_REG), 18, 1, 64'hFFFF_FFFF_FFF8_0000, 0, 'h4C);
        add_row("slli", enc_i('h03C, 2, 1, 19, OP_IMM), 19, 1, 64'hC000_0000_0000_0000, 0, 'h50);
        add_row("srli", enc_i('h020, 6, 5, 20, OP_IMM), 20, 1, 64'h0000_0000_FFFF_FFFF, 0, 'h54);
        add_row("srai", enc_i('h41C, 6, 5, 21, OP_IMM), 21, 1, 64'hFFFF_FFFF_FFFF_FFF8, 0, 'h58);
        add_row("lui_pos", enc_u('h7FFFF, 22, OP_LUI), 22, 1, 64'h7FFF_F000, 0, 'h5C);
        add_row("addw", enc_r(0, 22, 22, 0, 23, OP_REGW), 23, 1, 64'hFFFF_FFFF_FFFF_E000, 0, 'h60);
        add_row("subw", enc_r('h20, 22, 2, 0, 24, OP_REGW), 24, 1, 64'hFFFF_FFFF_8000_100C, 0, 'h64);
        add_row("addiw", enc_i(-1, 6, 0, 25, OP_IMMW), 25, 1, 64'h7FFF_FFFF, 0, 'h68);
        add_row("sllw", enc_r(0, 1, 5, 1, 26, OP_REGW), 26, 1, 64'hFFFF_FFFF_D800_0000, 0, 'h6C);
        add_row("srlw", enc_r(0, 2, 6, 5, 27, OP_REGW), 27, 1, 64'h0008_0000, 0, 'h70);
        add_row("sraw", enc_r('h20, 2, 6, 5, 28, OP_REGW), 28, 1, 64'hFFFF_FFFF_FFF8_0000, 0, 'h74);
        add_row("slliw", enc_i('h01D, 2, 1, 29, OP_IMMW), 29, 1, 64'hFFFF_FFFF_8000_0000, 0, 'h78);
        add_row("srliw", enc_i('h004, 23, 5, 30, OP_IMMW), 30, 1, 64'h0FFF_FE00, 0, 'h7C);
        add_row("sraiw", enc_i('h404, 23, 5, 31, OP_IMMW), 31, 1, 64'hFFFF_FFFF_FFFF_FE00, 0, 'h80);
        // Branch rd fields carry offset bits, which is 8 for a forward offset of 8.
        add_row("beq_taken", enc_b(8, 7, 7, 0), 8, 0, 64'h0, 0, 'h88);
        add_row("beq_not", enc_b(8, 2, 7, 0), 8, 0, 64'h0, 0, 'h8C);
        add_row("bne_taken", enc_b(8, 2, 7, 1), 8, 0, 64'h0, 0, 'h94);
        add_row("bne_not", enc_b(8, 2, 2, 1), 8, 0, 64'h0, 0, 'h98);
        add_row("blt_taken", enc_b(8, 2, 1, 4), 8, 0, 64'h0, 0, 'hA0);
        add_row("blt_not", enc_b(8, 1, 2, 4), 8, 0, 64'h0, 0, 'hA4);
        add_row("bge_taken", enc_b(8, 1, 2, 5), 8, 0, 64'h0, 0, 'hAC);
        add_row("bge_not", enc_b(8, 2, 1, 5), 8, 0, 64'h0, 0, 'hB0);
        add_row("bltu_taken", enc_b(8, 1, 2, 6), 8, 0, 64'h0, 0, 'hB8);
        add_row("bltu_not", enc_b(8, 2, 1, 6), 8, 0, 64'h0, 0, 'hBC);
        add_row("bgeu_taken", enc_b(8, 2, 1, 7), 8, 0, 64'h0, 0, 'hC4);
        add_row("bgeu_not", enc_b(8, 1, 2, 7), 8, 0, 64'h0, 0, 'hC8);
        add_row("jal", enc_j(16, 9), 9, 1, 64'hCC, 0, 'hD8);
        add_row("auipc", enc_u('h1, 10, OP_AUIPC), 10, 1, 64'h10D8, 0, 'hDC);
        add_row("addi_odd", enc_i('h0F1, 0, 0, 11, OP_IMM), 11, 1, 64'hF1, 0, 'hE0);
        add_row("jalr_odd", enc_i(0, 11, 0, 12, OP_JALR), 12, 1, 64'hE4, 0, 'hF0);
        add_row("ld_addr", enc_i(-4, 2, 3, 13, OP_LOAD), 13, 1, 64'h8, 0, 'hF4);
        add_row("sw_addr", enc_s('h10, 2, 9, 2), 16, 0, 64'hDC, 0, 'hF8);
        add_row("illegal_zero", 32'h0, 0, 0, 64'h0, 1, 'hFC);
        add_row("addi_after", enc_i(1, 13, 0, 14, OP_IMM), 14, 1, 64'h9, 0, 'h100);
    endtask

    // Wishbone slave with 0 to 3 random wait states per read.
    always @(negedge clk) begin : wb_memory
        string    nm;
        logic     busy;
        int       waits;
        addr_t    req_adr;
        nm = (fetch_count < num_rows) ? row_name[fetch_count] : "past_end";
        if (!arst_n) begin
            busy = 1'b0;
            wb_ack <= 1'b0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0; // The DUT leaves FS_FETCH on the acked edge.
        end else if (wb_cyc && wb_stb) begin
            if (!busy) begin
                busy = 1'b1;
                req_adr = wb_adr;
                waits = next_rand_bit();
                waits = (waits << 1) | next_rand_bit();
                if (fetch_count < num_rows) check_eq(nm, "fetch adr", row_pc[fetch_count], wb_adr);
            end else begin
                check_eq(nm, "held adr", req_adr, wb_adr);
            end
            if (waits == 0) begin
                wb_dat <= (wb_adr[63:9] == '0) ? mem[wb_adr[8:2]] : ~wb_adr[31:0];
                wb_ack <= 1'b1;
                busy = 1'b0;
                fetch_count++;
            end else begin
                waits--;
            end
        end
    end

    initial begin
        wait (build_done);
        #((num_rows * (4 + 3) + 16 + 40) * 4);
        $display("ERROR: watchdog expired, a retire never arrived in time");
        $display("sim failed");
        $finish;
    end

    initial begin
        int errs_before;
        int rows_failed;
        arst_n = 1'b0;
        wb_ack = 1'b0;
        wb_dat = '0;
        rows_failed = 0;
        build_program();
        build_done = 1'b1;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < num_rows; i++) begin
            errs_before = errors;
            do @(negedge clk); while (!retire_valid);
            check_eq(row_name[i], "retire_pc", row_pc[i], retire_pc);
            check_eq(row_name[i], "retire_rd", row_rd[i], retire_rd);
            check_eq(row_name[i], "retire_we", row_we[i], retire_we);
            check_eq(row_name[i], "retire_value", row_value[i], retire_value);
            check_eq(row_name[i], "retire_illegal", row_ill[i], retire_illegal);
            check_eq(row_name[i], "fetch count", i + 1, fetch_count);
            check_eq(row_name[i], "wb_cyc in exec", 0, wb_cyc); // No bus request while executing.
            check_eq(row_name[i], "wb_stb in exec", 0, wb_stb);
            @(negedge clk); // The next fetch address is the updated PC.
            check_eq(row_name[i], "wb_cyc in fetch", 1, wb_cyc);
            check_eq(row_name[i], "wb_stb in fetch", 1, wb_stb);
            check_eq(row_name[i], "next pc", row_next[i], wb_adr);
            if (errors == errs_before) begin
                $display("ok    %s", row_name[i]);
            end else begin
                $display("FAIL  %s", row_name[i]);
                rows_failed++;
            end
        end
        $display("rows %0d, passed %0d, failed %0d, check errors %0d",
                 num_rows, num_rows - rows_failed, rows_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end
endmodule
